// ==== hdl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // Instruction address width
    localparam int ADDR_BITS = 32;

    // History length sets the PHT depth too
    localparam int GHR_BITS = 4;

    // BTB index taken from word address bits
    localparam int BTB_IDX_BITS = 4;
    localparam int BTB_IDX_LSB = 2;
    localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [GHR_BITS-1:0] ghist_t;
    typedef logic [1:0] ctr_t;
    typedef logic [BTB_IDX_BITS-1:0] btb_idx_t;
    // Upper address bits above the index
    typedef logic [ADDR_BITS-BTB_TAG_LSB-1:0] btb_tag_t;

    // Saturating counter states
    localparam ctr_t CTR_SNT = 2'd0;
    localparam ctr_t CTR_WNT = 2'd1;
    localparam ctr_t CTR_WT = 2'd2;
    localparam ctr_t CTR_ST = 2'd3;

    // Sequential fetch step of one 32-bit instruction
    localparam addr_t PC_STEP = 32'd4;

endpackage

`default_nettype wire

// ==== hdl/bp_resolve_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bp_resolve_if;
    import bp_pkg::*;

    // Branch resolved in EX this cycle
    logic branch;
    // Resolved direction
    logic taken;
    // Address of the resolved instruction
    addr_t pc;
    // Resolved target address
    addr_t target;
    // Unconditional jump
    logic jump;
    // Instruction was a BTB hit when fetched
    logic hit;

    // Table updates read every field
    modport table_side (input branch, taken, pc, target, jump, hit);

    // Redirect decision in the program counter
    modport pc_side (input taken, target, jump, hit);

endinterface

`default_nettype wire

// ==== hdl/bp_fetch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bp_fetch_if;
    import bp_pkg::*;

    // Current fetch address
    addr_t pc;
    // BTB lookup result
    logic btb_hit;
    addr_t btb_target;
    // PHT direction for the current history
    logic pred_taken;

    modport pc_side (output pc, input btb_hit, btb_target, pred_taken);
    modport btb_side (input pc, output btb_hit, btb_target);
    modport pht_side (output pred_taken);
    // Correction buffer only observes the lookup
    modport cb_side (input pc, btb_hit, btb_target, pred_taken);

endinterface

`default_nettype wire

// ==== hdl/global_history_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module global_history_register (
    input wire logic clk,
    input wire logic rst_n,
    bp_resolve_if.table_side resolve,
    output bp_pkg::ghist_t history
);
    import bp_pkg::*;

    // Newest outcome enters at bit 0
    ghist_t history_nxt;

    always_comb begin
        history_nxt = {history[GHR_BITS-2:0], resolve.taken};
    end

    // Only resolved branches shift the history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            history <= '0;
        end else if (resolve.branch) begin
            history <= history_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pattern_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_history_table (
    input wire logic clk,
    input wire logic rst_n,
    bp_resolve_if.table_side resolve,
    input wire bp_pkg::ghist_t history,
    bp_fetch_if.pht_side fetch
);
    import bp_pkg::*;

    // One counter per history pattern
    localparam int PHT_DEPTH = 2 ** GHR_BITS;

    ctr_t pht [PHT_DEPTH];

    // Counter selected by the current history
    ctr_t cur_ctr;
    ctr_t nxt_ctr;

    assign cur_ctr = pht[history];

    // Upper bit set means weak or strong taken
    assign fetch.pred_taken = cur_ctr[1];

    // Saturating step toward the resolved outcome
    always_comb begin
        nxt_ctr = cur_ctr;
        if (resolve.taken) begin
            if (cur_ctr != CTR_ST) begin
                nxt_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != CTR_SNT) begin
                nxt_ctr = cur_ctr - 2'd1;
            end
        end
    end

    // All counters start weakly not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= CTR_WNT;
            end
        end else if (resolve.branch) begin
            pht[history] <= nxt_ctr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_target_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input wire logic clk,
    input wire logic rst_n,
    bp_resolve_if.table_side resolve,
    bp_fetch_if.btb_side fetch
);
    import bp_pkg::*;

    // One valid bit per entry
    logic [BTB_ENTRIES-1:0] valid;
    // Tag and target payload
    btb_tag_t tags [BTB_ENTRIES];
    addr_t targets [BTB_ENTRIES];

    // Fetch side lookup fields
    btb_idx_t fetch_idx;
    btb_tag_t fetch_tag;

    // Resolve side write fields
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic wr_en;

    assign fetch_idx = fetch.pc[BTB_TAG_LSB-1:BTB_IDX_LSB];
    assign fetch_tag = fetch.pc[ADDR_BITS-1:BTB_TAG_LSB];

    assign wr_idx = resolve.pc[BTB_TAG_LSB-1:BTB_IDX_LSB];
    assign wr_tag = resolve.pc[ADDR_BITS-1:BTB_TAG_LSB];

    // Only taken branches are worth a target entry
    assign wr_en = resolve.branch && resolve.taken;

    // Direct-mapped lookup with a single tag compare
    assign fetch.btb_hit = valid[fetch_idx] && (tags[fetch_idx] == fetch_tag);
    assign fetch.btb_target = targets[fetch_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Conflicting branch simply replaces the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_idx] <= wr_tag;
            targets[wr_idx] <= resolve.target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_correction_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_correction_buffer #(
    parameter int CB_DEPTH = 4
) (
    input wire logic clk,
    input wire logic rst_n,
    bp_resolve_if.table_side resolve,
    bp_fetch_if.cb_side fetch,
    output logic wrong,
    output bp_pkg::addr_t reverse_pc
);
    import bp_pkg::*;

    localparam int PTR_BITS = (CB_DEPTH > 1) ? $clog2(CB_DEPTH) : 1;

    // Entry payload for each predicted hit
    addr_t entry_pc [CB_DEPTH];
    logic entry_dir [CB_DEPTH];
    addr_t entry_alt [CB_DEPTH];

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0] count;

    logic empty;
    logic full;
    logic push;
    logic pop;
    logic flush;
    logic redirect;
    addr_t alt_addr;

    assign empty = (count == '0);
    assign full = (count == (PTR_BITS+1)'(CB_DEPTH));

    // Other way of the prediction
    assign alt_addr = fetch.pred_taken ? (fetch.pc + PC_STEP) : fetch.btb_target;

    // Push dropped when full
    assign push = fetch.btb_hit && !full;
    assign pop = resolve.branch && resolve.hit && !empty;

    // Head entry disagrees with the resolved direction
    assign wrong = pop && (entry_pc[head] == resolve.pc) && (entry_dir[head] != resolve.taken);
    assign reverse_pc = entry_alt[head];

    // Redirects from EX make every queued prediction stale
    assign redirect = resolve.jump || (resolve.taken && !resolve.hit);
    assign flush = wrong || redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_BITS'(CB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_BITS'(CB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // Net occupancy change
            count <= count + (PTR_BITS+1)'(push) - (PTR_BITS+1)'(pop);
        end
    end

    // Payload written at the tail
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            entry_pc[tail] <= fetch.pc;
            entry_dir[tail] <= fetch.pred_taken;
            entry_alt[tail] <= alt_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter bp_pkg::addr_t RESET_PC = '0
) (
    input wire logic clk,
    input wire logic rst_n,
    bp_resolve_if.pc_side resolve,
    bp_fetch_if.pc_side fetch,
    input wire logic wrong,
    input wire bp_pkg::addr_t reverse_pc,
    input wire logic exception,
    input wire logic mret,
    input wire bp_pkg::addr_t trap_vector,
    input wire bp_pkg::addr_t epc,
    output logic forced_redirect
);
    import bp_pkg::*;

    addr_t pc_q;
    addr_t pc_nxt;
    logic use_pred;

    // Jump, or a taken branch the BTB never predicted
    assign forced_redirect = resolve.jump || (resolve.taken && !resolve.hit);

    // Predicted taken only with a known target
    assign use_pred = fetch.btb_hit && fetch.pred_taken;

    // Fixed priority with traps first
    always_comb begin
        if (exception) begin
            pc_nxt = trap_vector;
        end else if (mret) begin
            pc_nxt = epc;
        end else if (forced_redirect) begin
            pc_nxt = resolve.target;
        end else if (wrong) begin
            // Undo a wrong direction
            pc_nxt = reverse_pc;
        end else if (use_pred) begin
            pc_nxt = fetch.btb_target;
        end else begin
            pc_nxt = pc_q + PC_STEP;
        end
    end

    // Fetch advances every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign fetch.pc = pc_q;

endmodule

`default_nettype wire

// ==== hdl/global_prediction_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module global_prediction_top #(
    parameter int BTB_ENTRIES = 16,
    parameter int CB_DEPTH = 4,
    parameter bp_pkg::addr_t RESET_PC = '0
) (
    input wire logic clk,
    input wire logic rst_n,
    // Resolved branch from EX
    input wire logic ex_branch,
    input wire logic ex_taken,
    input wire logic ex_jump,
    input wire logic ex_hit,
    input wire bp_pkg::addr_t ex_pc,
    input wire bp_pkg::addr_t ex_target,
    // Trap entry and return
    input wire logic exception,
    input wire logic mret,
    input wire bp_pkg::addr_t trap_vector,
    input wire bp_pkg::addr_t epc,
    // Fetch side
    output bp_pkg::addr_t pc,
    output logic hit,
    output logic pred_taken,
    output logic wrong,
    output logic forced_redirect
);
    import bp_pkg::*;

    bp_resolve_if resolve ();
    bp_fetch_if fetch ();

    ghist_t history;
    addr_t reverse_pc;

    // EX stage onto the resolve bundle
    assign resolve.branch = ex_branch;
    assign resolve.taken = ex_taken;
    assign resolve.jump = ex_jump;
    assign resolve.hit = ex_hit;
    assign resolve.pc = ex_pc;
    assign resolve.target = ex_target;

    global_history_register i_ghr (
        .clk (clk),
        .rst_n (rst_n),
        .resolve (resolve.table_side),
        .history (history)
    );

    pattern_history_table i_pht (
        .clk (clk),
        .rst_n (rst_n),
        .resolve (resolve.table_side),
        .history (history),
        .fetch (fetch.pht_side)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_btb (
        .clk (clk),
        .rst_n (rst_n),
        .resolve (resolve.table_side),
        .fetch (fetch.btb_side)
    );

    branch_correction_buffer #(
        .CB_DEPTH (CB_DEPTH)
    ) i_bcb (
        .clk (clk),
        .rst_n (rst_n),
        .resolve (resolve.table_side),
        .fetch (fetch.cb_side),
        .wrong (wrong),
        .reverse_pc (reverse_pc)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) i_pc (
        .clk (clk),
        .rst_n (rst_n),
        .resolve (resolve.pc_side),
        .fetch (fetch.pc_side),
        .wrong (wrong),
        .reverse_pc (reverse_pc),
        .exception (exception),
        .mret (mret),
        .trap_vector (trap_vector),
        .epc (epc),
        .forced_redirect (forced_redirect)
    );

    // Lookup results out to fetch
    assign pc = fetch.pc;
    assign hit = fetch.btb_hit;
    assign pred_taken = fetch.pred_taken;

endmodule

`default_nettype wire

// ==== tests/tb_global_prediction.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_global_prediction;
    import bp_pkg::*;

    localparam int BTB_ENTRIES = 16;
    localparam int CB_DEPTH = 4;
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Fixed addresses used by the directed tests
    localparam addr_t BR_B = 32'h0000_0040;
    localparam addr_t TGT_T = 32'h0000_0100;
    localparam addr_t BR_C = 32'h0000_0800;
    localparam addr_t TGT_D = 32'h0000_0900;
    localparam addr_t TRAIN_PC = 32'h0000_0310;
    localparam addr_t TRAIN_TGT = 32'h0000_0600;
    localparam addr_t JUMP_TGT = 32'h0000_0c00;
    localparam addr_t TRAP_VEC = 32'h0000_0f00;
    localparam addr_t EPC_VAL = 32'h0000_0a00;

    // Run length
    localparam int RAND_CYCLES = 64;
    localparam int TEST_CYCLES = 16 + 12 + 24 + RAND_CYCLES + 28 + 24 + 12;
    localparam int MAX_CYCLES = TEST_CYCLES + 200;

    logic clk;
    logic rst_n;
    logic ex_branch;
    logic ex_taken;
    logic ex_jump;
    logic ex_hit;
    addr_t ex_pc;
    addr_t ex_target;
    logic exception;
    logic mret;
    addr_t trap_vector;
    addr_t epc;
    addr_t pc;
    logic hit;
    logic pred_taken;
    logic wrong;
    logic forced_redirect;

    // Reference model state
    addr_t m_pc;
    ghist_t m_hist;
    ctr_t m_ctr [16];
    logic m_valid [BTB_ENTRIES];
    btb_tag_t m_tag [BTB_ENTRIES];
    addr_t m_tgt [BTB_ENTRIES];
    addr_t cb_pc [$];
    logic cb_dir [$];
    addr_t cb_alt [$];
    logic [3:0] m_idx;
    logic m_push;

    // Model outputs for the current cycle
    logic exp_hit;
    addr_t exp_tgt;
    logic exp_pred;
    logic exp_fr;
    logic exp_pop;
    logic exp_wrong;
    addr_t exp_next;

    int err_count = 0;
    int test_errs = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    int cycle_count = 0;
    logic [31:0] rnd;

    global_prediction_top #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .CB_DEPTH (CB_DEPTH),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk (clk),
        .rst_n (rst_n),
        .ex_branch (ex_branch),
        .ex_taken (ex_taken),
        .ex_jump (ex_jump),
        .ex_hit (ex_hit),
        .ex_pc (ex_pc),
        .ex_target (ex_target),
        .exception (exception),
        .mret (mret),
        .trap_vector (trap_vector),
        .epc (epc),
        .pc (pc),
        .hit (hit),
        .pred_taken (pred_taken),
        .wrong (wrong),
        .forced_redirect (forced_redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected outputs settle mid-cycle from model state and inputs
    always @(negedge clk) begin
        m_idx = m_pc[5:2];
        exp_hit = m_valid[m_idx] && (m_tag[m_idx] == m_pc[31:6]);
        exp_tgt = m_tgt[m_idx];
        // Taken at counter 2 or 3
        exp_pred = (m_ctr[m_hist] >= 2'd2);
        exp_fr = ex_jump || (ex_taken && !ex_hit);
        exp_pop = ex_branch && ex_hit && (cb_pc.size() > 0);
        exp_wrong = exp_pop && (cb_pc[0] == ex_pc) && (cb_dir[0] != ex_taken);
        if (exception) begin
            exp_next = trap_vector;
        end else if (mret) begin
            exp_next = epc;
        end else if (exp_fr) begin
            exp_next = ex_target;
        end else if (exp_wrong) begin
            exp_next = cb_alt[0];
        end else if (exp_hit && exp_pred) begin
            exp_next = exp_tgt;
        end else begin
            exp_next = m_pc + 32'd4;
        end
    end

    // Model state updates on the same edge as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            m_pc <= RESET_PC;
            m_hist <= '0;
            for (int i = 0; i < 16; i++) begin
                m_ctr[i] <= CTR_WNT;
                m_valid[i] <= 1'b0;
            end
            cb_pc.delete();
            cb_dir.delete();
            cb_alt.delete();
        end else begin
            m_pc <= exp_next;
            if (ex_branch) begin
                m_hist <= {m_hist[2:0], ex_taken};
                if (ex_taken && m_ctr[m_hist] != CTR_ST) begin
                    m_ctr[m_hist] <= m_ctr[m_hist] + 2'd1;
                end else if (!ex_taken && m_ctr[m_hist] != CTR_SNT) begin
                    m_ctr[m_hist] <= m_ctr[m_hist] - 2'd1;
                end
            end
            // Taken branches allocate and a conflict overwrites
            if (ex_branch && ex_taken) begin
                m_valid[ex_pc[5:2]] <= 1'b1;
                m_tag[ex_pc[5:2]] <= ex_pc[31:6];
                m_tgt[ex_pc[5:2]] <= ex_target;
            end
            if (exp_wrong || exp_fr) begin
                cb_pc.delete();
                cb_dir.delete();
                cb_alt.delete();
            end else begin
                // Full test before the pop
                m_push = exp_hit && (cb_pc.size() < CB_DEPTH);
                if (exp_pop) begin
                    void'(cb_pc.pop_front());
                    void'(cb_dir.pop_front());
                    void'(cb_alt.pop_front());
                end
                if (m_push) begin
                    cb_pc.push_back(m_pc);
                    cb_dir.push_back(exp_pred);
                    cb_alt.push_back(exp_pred ? m_pc + 32'd4 : exp_tgt);
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("Error: %s expected %h, got %h at cycle %0d", name, expected, actual,
                 cycle_count);
    endtask

    // Per-cycle comparison with the model
    pc_check: assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
        else report_mismatch("pc", $sampled(m_pc), $sampled(pc));
    hit_check: assert property (@(posedge clk) disable iff (!rst_n) hit == exp_hit)
        else report_mismatch("hit", $sampled(exp_hit), $sampled(hit));
    pred_check: assert property (@(posedge clk) disable iff (!rst_n) pred_taken == exp_pred)
        else report_mismatch("pred_taken", $sampled(exp_pred), $sampled(pred_taken));
    wrong_check: assert property (@(posedge clk) disable iff (!rst_n) wrong == exp_wrong)
        else report_mismatch("wrong", $sampled(exp_wrong), $sampled(wrong));
    redirect_check: assert property (@(posedge clk) disable iff (!rst_n)
                                     forced_redirect == exp_fr)
        else report_mismatch("forced_redirect", $sampled(exp_fr), $sampled(forced_redirect));

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // One EX-stage bundle for one cycle
    task automatic drive_ex(input logic br, input logic tk, input logic jp, input logic ht,
                            input addr_t p, input addr_t t);
        @(posedge clk);
        ex_branch <= br;
        ex_taken <= tk;
        ex_jump <= jp;
        ex_hit <= ht;
        ex_pc <= p;
        ex_target <= t;
        exception <= 1'b0;
        mret <= 1'b0;
    endtask

    task automatic idle();
        drive_ex(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic jump_to(input addr_t a);
        drive_ex(1'b0, 1'b0, 1'b1, 1'b0, '0, a);
    endtask

    // Six same-direction resolves fill the history and move its counter twice
    task automatic train(input logic tk);
        repeat (6) drive_ex(1'b1, tk, 1'b0, 1'b0, TRAIN_PC, TRAIN_TGT);
    endtask

    // Fetch BR_C and resolve it against its prediction before checking the next pc
    task automatic mispredict(input logic exc, input logic mr, input logic jp,
                              input addr_t expect_next);
        logic dir;
        jump_to(BR_C);
        idle();
        @(negedge clk);
        // Model counter for the current history
        dir = (m_ctr[m_hist] >= 2'd2);
        check_value("hit", 32'd1, hit);
        drive_ex(1'b1, !dir, jp, 1'b1, BR_C, jp ? JUMP_TGT : TGT_D);
        exception <= exc;
        mret <= mr;
        @(negedge clk);
        check_value("wrong", 32'd1, wrong);
        idle();
        @(negedge clk);
        check_value("pc", expect_next, pc);
    endtask

    task automatic finish_test(input string name);
        idle();
        @(negedge clk);
        if (err_count == test_errs) begin
            pass_tests++;
            $display("%s: passed", name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rnd = $urandom(32'h2db9debd);
        rst_n = 1'b0;
        ex_branch = 1'b0;
        ex_taken = 1'b0;
        ex_jump = 1'b0;
        ex_hit = 1'b0;
        ex_pc = '0;
        ex_target = '0;
        exception = 1'b0;
        mret = 1'b0;
        trap_vector = TRAP_VEC;
        epc = EPC_VAL;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values then sequential fetch
        @(negedge clk);
        check_value("pc", RESET_PC, pc);
        check_value("hit", 32'd0, hit);
        check_value("wrong", 32'd0, wrong);
        check_value("forced_redirect", 32'd0, forced_redirect);
        repeat (8) idle();
        @(negedge clk);
        check_value("pc", RESET_PC + 32'd32, pc);
        finish_test("reset and sequential fetch");

        // Unknown taken branch redirects and is then learned
        drive_ex(1'b1, 1'b1, 1'b0, 1'b0, BR_B, TGT_T);
        @(negedge clk);
        check_value("forced_redirect", 32'd1, forced_redirect);
        idle();
        @(negedge clk);
        check_value("pc", TGT_T, pc);
        jump_to(BR_B);
        idle();
        @(negedge clk);
        check_value("hit", 32'd1, hit);
        repeat (6) drive_ex(1'b1, 1'b1, 1'b0, 1'b1, BR_B, TGT_T);
        jump_to(BR_B);
        idle();
        idle();
        @(negedge clk);
        check_value("pc", TGT_T, pc);
        finish_test("learning a taken branch");

        // Mostly taken in the first half and mostly not taken after
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rnd = $urandom;
            drive_ex(rnd[0] | rnd[3],
                     (i < RAND_CYCLES / 2) ? (rnd[1] | rnd[5]) : (rnd[1] & rnd[5]),
                     1'b0, rnd[2], 32'h0000_0200 + {rnd[7:4], 2'b00},
                     $urandom & 32'hffff_fffc);
        end
        finish_test("random resolve stream");

        // Predicted taken then resolved not taken and the reverse
        drive_ex(1'b1, 1'b1, 1'b0, 1'b0, BR_C, TGT_D);
        train(1'b1);
        mispredict(1'b0, 1'b0, 1'b0, BR_C + 32'd4);
        train(1'b0);
        mispredict(1'b0, 1'b0, 1'b0, TGT_D);
        finish_test("misprediction correction");

        // Jump against wrong first while the stored target is still TGT_D
        mispredict(1'b0, 1'b0, 1'b1, JUMP_TGT);
        mispredict(1'b1, 1'b1, 1'b1, TRAP_VEC);
        mispredict(1'b0, 1'b1, 1'b1, EPC_VAL);
        mispredict(1'b1, 1'b0, 1'b0, TRAP_VEC);
        finish_test("redirect priority");

        // Same index with different tags
        drive_ex(1'b1, 1'b1, 1'b0, 1'b0, 32'h0000_1008, 32'h0000_1100);
        drive_ex(1'b1, 1'b1, 1'b0, 1'b0, 32'h0000_2008, 32'h0000_2100);
        jump_to(32'h0000_1008);
        idle();
        @(negedge clk);
        check_value("hit", 32'd0, hit);
        jump_to(32'h0000_2008);
        idle();
        @(negedge clk);
        check_value("hit", 32'd1, hit);
        finish_test("BTB conflict");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_tests, fail_tests,
                 err_count);
        if (err_count == 0 && fail_tests == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/bp_pkg.sv
hdl/bp_resolve_if.sv
hdl/bp_fetch_if.sv
hdl/global_history_register.sv
hdl/pattern_history_table.sv
hdl/branch_target_buffer.sv
hdl/branch_correction_buffer.sv
hdl/program_counter.sv
hdl/global_prediction_top.sv
tests/tb_global_prediction.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_global_prediction -Mdir obj_dir
	./obj_dir/Vtb_global_prediction | tee sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
